// ==== Bender.yml ====
package:
  name: sparse_skip

sources:
  - files:
      - verilog/sparse_skip_pkg.sv
      - verilog/sasa_bus_arbiter.sv
      - verilog/sasa_table.sv
      - verilog/sparsity_tracker.sv
      - verilog/skip_decider.sv
      - verilog/sparse_skip_top.sv
  - target: test
    files:
      - test/sparse_skip_tb.sv

// ==== sparse_skip.f ====
verilog/sparse_skip_pkg.sv
verilog/sasa_bus_arbiter.sv
verilog/sasa_table.sv
verilog/sparsity_tracker.sv
verilog/skip_decider.sv
verilog/sparse_skip_top.sv
test/sparse_skip_tb.sv

// ==== test/sparse_skip_tb.sv ====
`timescale 1ns/10ps

module sparse_skip_tb;

  localparam int N_TESTS     = 6;
  // roughly 60 cycles per test is plenty, then some margin
  localparam int CYCLE_LIMIT = N_TESTS * 60 + 100;

  logic        CLK;
  logic        nRST;
  logic        req0, req1, pc_valid, wb_wen;
  logic [31:0] addr0, data0, addr1, data1, pc, wb_data;
  logic [4:0]  wb_rd;
  logic        ack0, ack1, skip;
  logic [31:0] skip_pc;
  logic [4:0]  skip_count;

  // reference model of table, LRU order, enable and zero flags
  logic        m_valid [8][2];
  logic [10:0] m_tag   [8][2];
  logic [4:0]  m_rs1   [8][2];
  logic [4:0]  m_rs2   [8][2];
  logic        m_cond  [8][2];
  logic [4:0]  m_cnt   [8][2];
  int          m_stamp [8][2];
  int          stamp_ctr;
  logic        m_en;
  logic [31:0] m_zero;

  logic        exp_skip;
  logic [31:0] exp_pc;
  logic [4:0]  exp_cnt;
  logic        solo;
  logic [31:0] seed;
  int          errors;
  int          tests_done;
  int          cycles;

  sparse_skip_top u_dut (
    .CLK(CLK), .nRST(nRST),
    .req0(req0), .addr0(addr0), .data0(data0),
    .req1(req1), .addr1(addr1), .data1(data1),
    .pc(pc), .pc_valid(pc_valid),
    .wb_wen(wb_wen), .wb_rd(wb_rd), .wb_data(wb_data),
    .ack0(ack0), .ack1(ack1),
    .skip(skip), .skip_pc(skip_pc), .skip_count(skip_count)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  // count a failed check and print what went wrong
  task automatic record_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  a_ack_excl: assert property (@(posedge CLK) disable iff (!nRST) !(ack0 && ack1))
    else record_error($sformatf("both ack lines high at %0t", $time));
  a_ack0_rise: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(req0) && solo |-> ##3 $rose(ack0))
    else record_error($sformatf("ack0 did not rise on time at %0t", $time));
  a_ack1_rise: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(req1) && solo |-> ##3 $rose(ack1))
    else record_error($sformatf("ack1 did not rise on time at %0t", $time));
  a_ack0_fall: assert property (@(posedge CLK) disable iff (!nRST) ack0 && !req0 |=> !ack0)
    else record_error($sformatf("ack0 stayed high after req0 dropped at %0t", $time));
  a_ack1_fall: assert property (@(posedge CLK) disable iff (!nRST) ack1 && !req1 |=> !ack1)
    else record_error($sformatf("ack1 stayed high after req1 dropped at %0t", $time));
  a_ack0_hold: assert property (@(posedge CLK) disable iff (!nRST) ack0 && req0 |=> ack0)
    else record_error($sformatf("ack0 dropped while req0 still high at %0t", $time));
  a_ack1_hold: assert property (@(posedge CLK) disable iff (!nRST) ack1 && req1 |=> ack1)
    else record_error($sformatf("ack1 dropped while req1 still high at %0t", $time));
  a_skip: assert property (@(posedge CLK) disable iff (!nRST)
    pc_valid |=> skip == $past(exp_skip))
    else record_error($sformatf("MISMATCH at %0t: skip is %b", $time, skip));
  a_skip_fields: assert property (@(posedge CLK) disable iff (!nRST)
    pc_valid && exp_skip |=> skip_pc == $past(exp_pc) && skip_count == $past(exp_cnt))
    else record_error($sformatf("MISMATCH at %0t: skip_pc %h skip_count %0d", $time,
                                skip_pc, skip_count));

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] make_entry(input logic [15:0] p, input logic [4:0] r1,
                                             input logic [4:0] r2, input logic c,
                                             input logic [4:0] n);
    return {p, r1, r2, c, n};
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
    int s;
    int way;
    s = data[20:18];
    way = -1;
    if (addr == 32'h1000) begin
      for (int w = 0; w < 2; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == data[31:21]) way = w;
      end
      // no match, take the way used longest ago
      if (way < 0) way = (m_stamp[s][0] < m_stamp[s][1]) ? 0 : 1;
      m_valid[s][way] = 1'b1;
      m_tag[s][way]   = data[31:21];
      m_rs1[s][way]   = data[15:11];
      m_rs2[s][way]   = data[10:6];
      m_cond[s][way]  = data[5];
      m_cnt[s][way]   = data[4:0];
      m_stamp[s][way] = stamp_ctr++;
    end else if (addr == 32'h1004) begin
      m_en = data[0];
      if (data[1]) begin
        for (int i = 0; i < 8; i++) begin
          m_valid[i][0] = 1'b0;
          m_valid[i][1] = 1'b0;
        end
      end
    end
  endtask

  task automatic bus_write(input int port, input logic [31:0] addr, input logic [31:0] data);
    @(posedge CLK);
    #1;
    pc_valid = 1'b0;
    if (port == 0) begin
      req0  = 1'b1;
      addr0 = addr;
      data0 = data;
    end else begin
      req1  = 1'b1;
      addr1 = addr;
      data1 = data;
    end
    do begin
      @(posedge CLK);
      #1;
    end while (!(port == 0 ? ack0 : ack1));
    model_write(addr, data);
    // keep req up one more cycle, ack has to stay high meanwhile
    @(posedge CLK);
    #1;
    if (port == 0) req0 = 1'b0;
    else req1 = 1'b0;
    do begin
      @(posedge CLK);
      #1;
    end while (port == 0 ? ack0 : ack1);
  endtask

  task automatic writeback(input logic [4:0] rd, input logic [31:0] value);
    @(posedge CLK);
    #1;
    pc_valid = 1'b0;
    wb_wen  = 1'b1;
    wb_rd   = rd;
    wb_data = value;
    if (rd != 5'd0) m_zero[rd] = (value == 32'd0);
    @(posedge CLK);
    #1;
    wb_wen = 1'b0;
  endtask

  // drive one fetch and set what the model expects a cycle later
  task automatic lookup(input logic [15:0] p);
    int s;
    int way;
    s = p[4:2];
    way = -1;
    @(posedge CLK);
    #1;
    for (int w = 0; w < 2; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == p[15:5]) way = w;
    end
    exp_skip = 1'b0;
    if (m_en && way >= 0) begin
      m_stamp[s][way] = stamp_ctr++;
      exp_cnt  = m_cnt[s][way];
      exp_pc   = {16'd0, p} + 32'd4 * (exp_cnt + 32'd1);
      exp_skip = m_cond[s][way] ? (m_zero[m_rs1[s][way]] && m_zero[m_rs2[s][way]])
                                : (m_zero[m_rs1[s][way]] || m_zero[m_rs2[s][way]]);
    end
    pc = {16'd0, p};
    pc_valid = 1'b1;
  endtask

  task automatic end_test(input string name);
    tests_done++;
    $display("test %0d (%s) finished, errors so far %0d", tests_done, name, errors);
  endtask

  initial begin
    logic [15:0] p1, p2, p3, q1, q2;
    logic [4:0]  o1, o2, a2, r;
    logic [10:0] t;
    seed = 32'hcacb_1c16;
    errors = 0;
    tests_done = 0;
    cycles = 0;
    solo = 1'b1;
    nRST = 1'b0;
    req0 = 0;
    req1 = 0;
    addr0 = 0;
    data0 = 0;
    addr1 = 0;
    data1 = 0;
    pc = 0;
    pc_valid = 0;
    wb_wen = 0;
    wb_rd = 0;
    wb_data = 0;
    exp_skip = 0;
    exp_pc = 0;
    exp_cnt = 0;
    m_en = 1'b0;
    m_zero = '1;
    stamp_ctr = 2;
    for (int s = 0; s < 8; s++) begin
      for (int w = 0; w < 2; w++) begin
        m_valid[s][w] = 1'b0;
        m_stamp[s][w] = 1 - w;
      end
    end
    repeat (2) @(posedge CLK);
    #1 nRST = 1'b1;

    assert (!ack0 && !ack1 && !skip)
      else record_error($sformatf("MISMATCH at %0t: ack or skip not low after reset", $time));
    bus_write(0, 32'h1000, make_entry(16'h0100, 5'd1, 5'd2, 1'b0, 5'd3));
    lookup(16'h0100);
    end_test("reset and disabled");

    bus_write(1, 32'h1004, 32'h1);
    solo = 1'b0;
    fork
      bus_write(0, 32'h1000, make_entry(16'h0424, 5'd3, 5'd4, 1'b0, 5'd2));
      bus_write(1, 32'h1000, make_entry(16'h0838, 5'd5, 5'd6, 1'b1, 5'd7));
    join
    solo = 1'b1;
    lookup(16'h0424);
    lookup(16'h0838);
    lookup(16'h0100);
    end_test("handshake and round robin");

    o1 = next_rand() % 31 + 1;
    o2 = next_rand() % 31 + 1;
    a2 = next_rand() % 31 + 1;
    q1 = 16'h2008;
    q2 = 16'h200c;
    bus_write(0, 32'h1000, make_entry(q1, o1, o2, 1'b0, next_rand() % 32));
    bus_write(1, 32'h1000, make_entry(q2, 5'd0, a2, 1'b1, next_rand() % 32));
    for (int i = 0; i < 8; i++) begin
      case (next_rand() % 3)
        0: r = o1;
        1: r = o2;
        default: r = a2;
      endcase
      writeback(r, next_rand() % 2 ? 32'd0 : (next_rand() | 32'd1));
      lookup(q1);
      lookup(q2);
    end
    writeback(5'd0, 32'h5);
    lookup(q2);
    end_test("skip decision");

    t  = next_rand();
    p1 = {t, 3'd5, 2'b00};
    p2 = {t + 11'd1, 3'd5, 2'b00};
    p3 = {t + 11'd2, 3'd5, 2'b00};
    bus_write(0, 32'h1000, make_entry(p1, 5'd0, 5'd0, 1'b0, 5'd1));
    bus_write(0, 32'h1000, make_entry(p2, 5'd0, 5'd0, 1'b0, 5'd2));
    lookup(p1);
    bus_write(1, 32'h1000, make_entry(p3, 5'd0, 5'd0, 1'b0, 5'd3));
    lookup(p1);
    lookup(p2);
    lookup(p3);
    end_test("LRU replacement");

    bus_write(1, 32'h1000, make_entry(p1, 5'd0, 5'd0, 1'b1, 5'd9));
    lookup(p1);
    lookup(p3);
    end_test("in-place rewrite");

    bus_write(0, 32'h1004, 32'h3);
    lookup(p1);
    lookup(p3);
    lookup(16'h0100);
    bus_write(1, 32'h1000, make_entry(p2, 5'd0, 5'd0, 1'b0, 5'd4));
    lookup(p2);
    @(posedge CLK);
    #1 pc_valid = 1'b0;
    @(posedge CLK);
    end_test("flush");

    $display("tests run: %0d, errors: %0d", tests_done, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== verilog/sasa_bus_arbiter.sv ====
`timescale 1ns/10ps

module sasa_bus_arbiter import sparse_skip_pkg::*; (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  req0,
  input  logic [BUS_ADDR_W-1:0] addr0,
  input  logic [BUS_DATA_W-1:0] data0,
  input  logic                  req1,
  input  logic [BUS_ADDR_W-1:0] addr1,
  input  logic [BUS_DATA_W-1:0] data1,
  output logic                  ack0,
  output logic                  ack1,
  output logic                  bus_wen,
  output logic [BUS_ADDR_W-1:0] bus_addr,
  output logic [BUS_DATA_W-1:0] bus_data
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_WRITE = 2'd1;
  localparam logic [1:0] ST_ACK   = 2'd2;

  logic [1:0]            state_q;
  logic                  grant_q;
  logic                  grant;
  logic                  req_any;
  logic                  req_granted;
  logic                  ack_q;
  logic                  bus_wen_q;
  logic [BUS_ADDR_W-1:0] bus_addr_q;
  logic [BUS_DATA_W-1:0] bus_data_q;

  assign req_any = req0 | req1;

  // on contention serve the port that was not granted last time
  assign grant = (req0 && req1) ? ~grant_q : req1;

  // request line of the port currently being served
  assign req_granted = grant_q ? req1 : req0;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q   <= ST_IDLE;
      grant_q   <= 1'b1;
      ack_q     <= 1'b0;
      bus_wen_q <= 1'b0;
    end else begin
      bus_wen_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_any) begin
            state_q <= ST_WRITE;
            grant_q <= grant;
          end
        end
        ST_WRITE: begin
          bus_wen_q <= 1'b1;
          state_q   <= ST_ACK;
        end
        ST_ACK: begin
          // raise ack once the bus write has gone out, drop it when req falls
          if (bus_wen_q) begin
            ack_q <= 1'b1;
          end else if (ack_q && !req_granted) begin
            ack_q   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // capture the winner's address and data at grant time
  always_ff @(posedge CLK) begin
    if (state_q == ST_IDLE && req_any) begin
      bus_addr_q <= grant ? addr1 : addr0;
      bus_data_q <= grant ? data1 : data0;
    end
  end

  assign ack0     = ack_q & ~grant_q;
  assign ack1     = ack_q & grant_q;
  assign bus_wen  = bus_wen_q;
  assign bus_addr = bus_addr_q;
  assign bus_data = bus_data_q;

  a_ack_exclusive: assert property (@(posedge CLK) disable iff (!nRST) !(ack0 && ack1))
    else $error("both requester ports acknowledged at once");

  a_wen_single: assert property (@(posedge CLK) disable iff (!nRST) bus_wen |=> !bus_wen)
    else $error("bus_wen held high for more than one cycle");

endmodule

// ==== verilog/sasa_table.sv ====
`timescale 1ns/10ps

module sasa_table import sparse_skip_pkg::*; #(
  parameter int                    SASA_ENTRIES = 16,
  parameter int                    SASA_WAYS    = 2,
  parameter logic [BUS_ADDR_W-1:0] SASA_ADDR    = 32'h1000
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  bus_wen,
  input  logic [BUS_ADDR_W-1:0] bus_addr,
  input  logic [BUS_DATA_W-1:0] bus_data,
  input  logic [15:0]           pc,
  input  logic                  pc_valid,
  output logic                  hit,
  output logic [4:0]            hit_rs1,
  output logic [4:0]            hit_rs2,
  output sasa_cond_t            hit_cond,
  output logic [4:0]            hit_skip
);

  localparam int SETS     = SASA_ENTRIES / SASA_WAYS;
  localparam int SET_BITS = $clog2(SETS);
  localparam int SET_W    = (SETS > 1) ? SET_BITS : 1;
  localparam int WAY_W    = (SASA_WAYS > 1) ? $clog2(SASA_WAYS) : 1;
  // pc[1:0] is the byte offset, the set index sits right above it
  localparam int TAG_W    = 14 - SET_BITS;

  // age per way, 0 is most recently used, SASA_WAYS-1 is the victim
  logic [SETS-1:0][SASA_WAYS-1:0][WAY_W-1:0] age_q;
  logic [SETS-1:0][SASA_WAYS-1:0]            valid_q;
  logic                                      enable_q;

  logic [TAG_W-1:0] tag_q  [SETS][SASA_WAYS];
  logic [4:0]       rs1_q  [SETS][SASA_WAYS];
  logic [4:0]       rs2_q  [SETS][SASA_WAYS];
  sasa_cond_t       cond_q [SETS][SASA_WAYS];
  logic [4:0]       skip_q [SETS][SASA_WAYS];

  sasa_word_u       wr_word;
  logic             entry_wen;
  logic             ctrl_wen;
  logic [SET_W-1:0] wr_set;
  logic [TAG_W-1:0] wr_tag;
  logic [SET_W-1:0] pc_set;
  logic [TAG_W-1:0] pc_tag;

  logic [SASA_WAYS-1:0] pc_match;
  logic [SASA_WAYS-1:0] wr_match;
  logic [WAY_W-1:0]     hit_way;
  logic [WAY_W-1:0]     wr_way;
  logic                 wr_exists;
  logic                 lookup_hit;

  logic [SASA_WAYS-1:0][WAY_W-1:0] hit_ages;
  logic [SASA_WAYS-1:0][WAY_W-1:0] base_ages;
  logic [SASA_WAYS-1:0][WAY_W-1:0] wr_ages;

  // make one way most recently used, ways younger than it age by one
  function automatic logic [SASA_WAYS-1:0][WAY_W-1:0] touch(
    input logic [SASA_WAYS-1:0][WAY_W-1:0] ages,
    input logic [WAY_W-1:0]                way
  );
    logic [SASA_WAYS-1:0][WAY_W-1:0] result;
    result = ages;
    for (int i = 0; i < SASA_WAYS; i++) begin
      if (ages[i] < ages[way]) begin
        result[i] = ages[i] + 1'b1;
      end
    end
    result[way] = '0;
    return result;
  endfunction

  // bus decode, the address tells which view of the word applies
  assign wr_word   = bus_data;
  assign entry_wen = bus_wen && (bus_addr == SASA_ADDR);
  assign ctrl_wen  = bus_wen && (bus_addr == SASA_ADDR + 32'd4);
  assign wr_set    = (SETS > 1) ? wr_word.entry.prev_pc[2 +: SET_W] : '0;
  assign wr_tag    = wr_word.entry.prev_pc[15 -: TAG_W];

  assign pc_set = (SETS > 1) ? pc[2 +: SET_W] : '0;
  assign pc_tag = pc[15 -: TAG_W];

  always_comb begin
    pc_match = '0;
    wr_match = '0;
    for (int w = 0; w < SASA_WAYS; w++) begin
      pc_match[w] = valid_q[pc_set][w] && (tag_q[pc_set][w] == pc_tag);
      wr_match[w] = valid_q[wr_set][w] && (tag_q[wr_set][w] == wr_tag);
    end
  end

  always_comb begin
    hit_way   = '0;
    wr_way    = '0;
    wr_exists = 1'b0;
    for (int w = 0; w < SASA_WAYS; w++) begin
      if (pc_match[w]) begin
        hit_way = WAY_W'(w);
      end
      if (wr_match[w]) begin
        wr_exists = 1'b1;
        wr_way    = WAY_W'(w);
      end
    end
    // a hit in the written set counts first, then the write on top of it
    hit_ages  = touch(age_q[pc_set], hit_way);
    base_ages = (lookup_hit && (wr_set == pc_set)) ? hit_ages : age_q[wr_set];
    if (!wr_exists) begin
      for (int w = 0; w < SASA_WAYS; w++) begin
        if (base_ages[w] == WAY_W'(SASA_WAYS - 1)) begin
          wr_way = WAY_W'(w);
        end
      end
    end
    wr_ages = touch(base_ages, wr_way);
  end

  assign lookup_hit = enable_q && pc_valid && (pc_match != '0);

  assign hit      = lookup_hit;
  assign hit_rs1  = lookup_hit ? rs1_q[pc_set][hit_way] : 5'd0;
  assign hit_rs2  = lookup_hit ? rs2_q[pc_set][hit_way] : 5'd0;
  assign hit_cond = lookup_hit ? cond_q[pc_set][hit_way] : SASA_COND_OR;
  assign hit_skip = lookup_hit ? skip_q[pc_set][hit_way] : 5'd0;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      enable_q <= 1'b0;
      valid_q  <= '0;
      for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < SASA_WAYS; w++) begin
          age_q[s][w] <= WAY_W'(w);
        end
      end
    end else begin
      if (lookup_hit) begin
        age_q[pc_set] <= hit_ages;
      end
      // wr_ages already folds in a same-set hit
      if (entry_wen) begin
        valid_q[wr_set][wr_way] <= 1'b1;
        age_q[wr_set]           <= wr_ages;
      end
      if (ctrl_wen) begin
        enable_q <= wr_word.ctrl.enable;
        if (wr_word.ctrl.flush) begin
          valid_q <= '0;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (entry_wen) begin
      tag_q[wr_set][wr_way]  <= wr_tag;
      rs1_q[wr_set][wr_way]  <= wr_word.entry.rs1;
      rs2_q[wr_set][wr_way]  <= wr_word.entry.rs2;
      cond_q[wr_set][wr_way] <= wr_word.entry.cond;
      skip_q[wr_set][wr_way] <= wr_word.entry.insts_to_skip;
    end
  end

  // in-place update on rewrite keeps tags unique within a set
  a_single_match: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0(pc_match) && (!entry_wen || $onehot0(wr_match)))
    else $error("more than one way matches in a set");

endmodule

// ==== verilog/skip_decider.sv ====
`timescale 1ns/10ps

module skip_decider import sparse_skip_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic [31:0] pc,
  input  logic        hit,
  input  logic [4:0]  hit_rs1,
  input  logic [4:0]  hit_rs2,
  input  sasa_cond_t  hit_cond,
  input  logic [4:0]  hit_skip,
  input  logic [31:0] zero_flags,
  output logic        skip,
  output logic [31:0] skip_pc,
  output logic [4:0]  skip_count
);

  logic        rs1_zero;
  logic        rs2_zero;
  logic        cond_met;
  logic [31:0] skip_dist;

  assign rs1_zero = zero_flags[hit_rs1];
  assign rs2_zero = zero_flags[hit_rs2];

  always_comb begin
    case (hit_cond)
      SASA_COND_AND: cond_met = rs1_zero & rs2_zero;
      default:       cond_met = rs1_zero | rs2_zero;
    endcase
  end

  // resume after the hit instruction plus the skipped ones
  assign skip_dist = ({27'd0, hit_skip} + 32'd1) << 2;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      skip <= 1'b0;
    end else begin
      skip <= hit && cond_met;
    end
  end

  always_ff @(posedge CLK) begin
    skip_pc    <= pc + skip_dist;
    skip_count <= hit_skip;
  end

  a_skip_after_hit: assert property (@(posedge CLK) disable iff (!nRST) skip |-> $past(hit))
    else $error("skip raised without a table hit in the previous cycle");

endmodule

// ==== verilog/sparse_skip_pkg.sv ====
package sparse_skip_pkg;

  // configuration bus widths
  localparam int BUS_ADDR_W = 32;
  localparam int BUS_DATA_W = 32;

  // skip condition on the two source registers
  typedef enum logic {
    SASA_COND_OR  = 1'b0,
    SASA_COND_AND = 1'b1
  } sasa_cond_t;

  // layout of a word stored to the entry address
  typedef struct packed {
    logic [15:0] prev_pc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    sasa_cond_t  cond;
    logic [4:0]  insts_to_skip;
  } sasa_entry_word_t;

  // layout of a word stored to the control address
  typedef struct packed {
    logic [29:0] reserved;
    logic        flush;
    logic        enable;
  } sasa_ctrl_word_t;

  // the same bus data seen as an entry or as a control word,
  // picked by the write address
  typedef union packed {
    sasa_entry_word_t entry;
    sasa_ctrl_word_t  ctrl;
  } sasa_word_u;

endpackage

// ==== verilog/sparse_skip_top.sv ====
`timescale 1ns/10ps

module sparse_skip_top import sparse_skip_pkg::*; #(
  parameter int                    SASA_ENTRIES = 16,
  parameter int                    SASA_WAYS    = 2,
  parameter logic [BUS_ADDR_W-1:0] SASA_ADDR    = 32'h1000
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  req0,
  input  logic [BUS_ADDR_W-1:0] addr0,
  input  logic [BUS_DATA_W-1:0] data0,
  input  logic                  req1,
  input  logic [BUS_ADDR_W-1:0] addr1,
  input  logic [BUS_DATA_W-1:0] data1,
  input  logic [31:0]           pc,
  input  logic                  pc_valid,
  input  logic                  wb_wen,
  input  logic [4:0]            wb_rd,
  input  logic [31:0]           wb_data,
  output logic                  ack0,
  output logic                  ack1,
  output logic                  skip,
  output logic [31:0]           skip_pc,
  output logic [4:0]            skip_count
);

  // configuration bus
  logic                  bus_wen;
  logic [BUS_ADDR_W-1:0] bus_addr;
  logic [BUS_DATA_W-1:0] bus_data;

  // lookup result and register state
  logic        hit;
  logic [4:0]  hit_rs1;
  logic [4:0]  hit_rs2;
  sasa_cond_t  hit_cond;
  logic [4:0]  hit_skip;
  logic [31:0] zero_flags;

  sasa_bus_arbiter u_arbiter (
    .CLK      (CLK),
    .nRST     (nRST),
    .req0     (req0),
    .addr0    (addr0),
    .data0    (data0),
    .req1     (req1),
    .addr1    (addr1),
    .data1    (data1),
    .ack0     (ack0),
    .ack1     (ack1),
    .bus_wen  (bus_wen),
    .bus_addr (bus_addr),
    .bus_data (bus_data)
  );

  // the table only sees the low 16 bits of the fetch address
  sasa_table #(
    .SASA_ENTRIES (SASA_ENTRIES),
    .SASA_WAYS    (SASA_WAYS),
    .SASA_ADDR    (SASA_ADDR)
  ) u_table (
    .CLK      (CLK),
    .nRST     (nRST),
    .bus_wen  (bus_wen),
    .bus_addr (bus_addr),
    .bus_data (bus_data),
    .pc       (pc[15:0]),
    .pc_valid (pc_valid),
    .hit      (hit),
    .hit_rs1  (hit_rs1),
    .hit_rs2  (hit_rs2),
    .hit_cond (hit_cond),
    .hit_skip (hit_skip)
  );

  sparsity_tracker u_tracker (
    .CLK        (CLK),
    .nRST       (nRST),
    .wb_wen     (wb_wen),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .zero_flags (zero_flags)
  );

  skip_decider u_decider (
    .CLK        (CLK),
    .nRST       (nRST),
    .pc         (pc),
    .hit        (hit),
    .hit_rs1    (hit_rs1),
    .hit_rs2    (hit_rs2),
    .hit_cond   (hit_cond),
    .hit_skip   (hit_skip),
    .zero_flags (zero_flags),
    .skip       (skip),
    .skip_pc    (skip_pc),
    .skip_count (skip_count)
  );

endmodule

// ==== verilog/sparsity_tracker.sv ====
`timescale 1ns/10ps

module sparsity_tracker (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        wb_wen,
  input  logic [4:0]  wb_rd,
  input  logic [31:0] wb_data,
  output logic [31:0] zero_flags
);

  // one flag per architectural register, x0 is hardwired
  logic [31:1] flags_q;
  logic        wb_zero;

  assign wb_zero = (wb_data == 32'd0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      // the register file comes out of reset all zero
      flags_q <= '1;
    end else if (wb_wen && (wb_rd != 5'd0)) begin
      flags_q[wb_rd] <= wb_zero;
    end
  end

  assign zero_flags = {flags_q, 1'b1};

endmodule
